/* src/io_pkg.sv */
package io_pkg;

  typedef logic [31:0] word_t;

  // serial timing, kept short for simulation
  localparam int CLKS_PER_BIT = 8;

  localparam logic [7:0] BYTE_GREETING = 8'h99; // sent once after reset
  localparam logic [7:0] BYTE_LOADED   = 8'haa; // program received, core started

  // image geometry
  localparam int IMG_WIDTH  = 4;
  localparam int IMG_HEIGHT = 2;
  localparam int PIXELS     = IMG_WIDTH * IMG_HEIGHT;
  localparam int COLOR_MAX  = 255;

  localparam word_t DATA_BASE_ADDR = 32'h0000_0000; // first pixel word

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  localparam logic [7:0] ASCII_ZERO    = 8'h30;
  localparam logic [7:0] ASCII_SPACE   = 8'h20;
  localparam logic [7:0] ASCII_NEWLINE = 8'h0a;
  localparam logic [7:0] ASCII_P       = 8'h50;

  typedef struct packed {
    logic [31:0] addr; // byte address
    word_t       data;
  } instr_wr_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        rd;   // one-cycle read strobe
  } mem_rd_t;

  // red sits in the low byte of the memory word
  typedef struct packed {
    logic [7:0] blue;
    logic [7:0] green;
    logic [7:0] red;
  } rgb_pixel_t;

  typedef struct packed {
    logic [3:0] hund;
    logic [3:0] tens;
    logic [3:0] ones;
  } dec3_t;

  typedef enum logic [1:0] {LD_LEN, LD_WORD, LD_DONE} loader_state_e;

  typedef enum logic [3:0] {
    WR_INIT, WR_GREET, WR_WAIT_START, WR_LOADED, WR_WAIT_END, WR_HEADER,
    WR_READ, WR_WAIT_DATA, WR_HUND, WR_TENS, WR_ONES, WR_PIXEL, WR_IDLE
  } writer_state_e;

  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

endpackage

/* src/uart_rx.sv */
module uart_rx (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rxd,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  io_pkg::uart_state_e state;
  logic        rxd_meta;
  logic        rxd_s;     // synchronized line
  logic [15:0] clk_cnt;
  logic [2:0]  bit_cnt;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_s    <= rxd_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= io_pkg::UART_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 16'd1;
      case (state)
        io_pkg::UART_IDLE: begin
          clk_cnt <= '0;
          if (!rxd_s) state <= io_pkg::UART_START; // falling edge of start bit
        end
        io_pkg::UART_START: begin
          // re-check at mid start bit so a glitch is not taken as a frame
          if (clk_cnt == 16'(io_pkg::CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rxd_s ? io_pkg::UART_IDLE : io_pkg::UART_DATA;
          end
        end
        io_pkg::UART_DATA: begin
          if (clk_cnt == 16'(io_pkg::CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= io_pkg::UART_STOP;
          end
        end
        default: begin
          if (clk_cnt == 16'(io_pkg::CLKS_PER_BIT - 1)) begin
            rx_valid <= rxd_s;               // low stop bit drops the frame
            state    <= io_pkg::UART_IDLE;
          end
        end
      endcase
    end
  end

  // data register, lsb arrives first
  always_ff @(posedge clk) begin
    if (state == io_pkg::UART_DATA && clk_cnt == 16'(io_pkg::CLKS_PER_BIT - 1))
      rx_byte <= {rxd_s, rx_byte[7:1]};
  end

  a_valid_single: assert property (@(posedge clk) disable iff (!rstn)
    rx_valid |=> !rx_valid);

endmodule

/* src/uart_tx.sv */
module uart_tx (
  input  logic       clk,
  input  logic       rstn,
  input  logic       fifo_empty,
  input  logic [7:0] fifo_byte,
  output logic       pop,
  output logic       txd
);

  io_pkg::uart_state_e state;
  logic [15:0] clk_cnt;
  logic [2:0]  bit_cnt;
  logic [7:0]  shreg;

  assign pop = (state == io_pkg::UART_IDLE) && !fifo_empty;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= io_pkg::UART_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      txd     <= 1'b1;                         // line idles high
    end else begin
      clk_cnt <= clk_cnt + 16'd1;
      case (state)
        io_pkg::UART_IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          txd     <= !pop;                     // start bit goes out with the pop
          if (pop) state <= io_pkg::UART_START;
        end
        io_pkg::UART_START, io_pkg::UART_DATA: begin
          if (clk_cnt == 16'(io_pkg::CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (state == io_pkg::UART_DATA && bit_cnt == 3'd7) begin
              txd   <= 1'b1;
              state <= io_pkg::UART_STOP;
            end else begin
              txd <= shreg[0];
              if (state == io_pkg::UART_DATA) bit_cnt <= bit_cnt + 3'd1;
              state <= io_pkg::UART_DATA;
            end
          end
        end
        default: begin
          if (clk_cnt == 16'(io_pkg::CLKS_PER_BIT - 1)) state <= io_pkg::UART_IDLE;
        end
      endcase
    end
  end

  // payload shifter loaded from the fifo head on pop
  always_ff @(posedge clk) begin
    if (pop)
      shreg <= fifo_byte;
    else if (state != io_pkg::UART_IDLE && clk_cnt == 16'(io_pkg::CLKS_PER_BIT - 1))
      shreg <= {1'b0, shreg[7:1]};
  end

  // a new frame only starts after a full stop bit on the line
  a_pop_idle: assert property (@(posedge clk) disable iff (!rstn)
    pop |-> txd && $past(txd, io_pkg::CLKS_PER_BIT));

endmodule

/* src/program_loader.sv */
module program_loader (
  input  logic              clk,
  input  logic              rstn,
  input  logic [7:0]        rx_byte,
  input  logic              rx_valid,
  output io_pkg::instr_wr_t instr_wr,
  output logic              instr_wr_en,
  output logic              core_start
);

  io_pkg::loader_state_e state;
  logic [1:0]  byte_cnt;   // byte position inside length or word
  logic [31:0] len_bytes;
  logic [31:0] len_next;
  logic [29:0] num_words;
  logic [29:0] word_idx;

  assign len_next = {rx_byte, len_bytes[31:8]}; // length comes lsb first

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= io_pkg::LD_LEN;
      byte_cnt    <= '0;
      len_bytes   <= '0;
      num_words   <= '0;
      word_idx    <= '0;
      instr_wr_en <= 1'b0;
      core_start  <= 1'b0;
    end else begin
      instr_wr_en <= 1'b0;
      core_start  <= 1'b0;
      case (state)
        io_pkg::LD_LEN: begin
          if (rx_valid) begin
            len_bytes <= len_next;
            byte_cnt  <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
              num_words <= len_next[31:2];     // whole words only
              if (len_next[31:2] == '0) begin
                // empty program, start the core straight away
                core_start <= 1'b1;
                state      <= io_pkg::LD_DONE;
              end else begin
                state <= io_pkg::LD_WORD;
              end
            end
          end
        end
        io_pkg::LD_WORD: begin
          if (rx_valid) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
              instr_wr_en <= 1'b1;
              word_idx    <= word_idx + 30'd1;
              if (word_idx == num_words - 30'd1) begin
                core_start <= 1'b1;            // same cycle as the last write
                state      <= io_pkg::LD_DONE;
              end
            end
          end
        end
        default: ; // program loaded, later host bytes are ignored
      endcase
    end
  end

  // word assembly straight into the write payload
  always_ff @(posedge clk) begin
    if (state == io_pkg::LD_WORD && rx_valid) begin
      instr_wr.data <= {rx_byte, instr_wr.data[31:8]};
      instr_wr.addr <= {word_idx, 2'b00};
    end
  end

  a_no_write_in_len: assert property (@(posedge clk) disable iff (!rstn)
    state == io_pkg::LD_LEN |-> !instr_wr_en && !core_start);

endmodule

/* src/tx_byte_fifo.sv */
module tx_byte_fifo (
  input  logic       clk,
  input  logic       rstn,
  input  logic       push,
  input  logic [7:0] push_byte,
  input  logic       pop,
  output logic [7:0] fifo_byte,
  output logic       fifo_full,
  output logic       fifo_empty
);

  logic [7:0]                 mem [io_pkg::FIFO_DEPTH];
  logic [io_pkg::FIFO_AW-1:0] wr_ptr;
  logic [io_pkg::FIFO_AW-1:0] rd_ptr;
  logic [io_pkg::FIFO_AW:0]   count;

  assign fifo_byte  = mem[rd_ptr];   // head is always visible
  assign fifo_full  = (count == (io_pkg::FIFO_AW + 1)'(io_pkg::FIFO_DEPTH));
  assign fifo_empty = (count == '0);

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_byte;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, pointers wrap
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) push |-> !fifo_full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) pop |-> !fifo_empty);

endmodule

/* src/frame_writer.sv */
module frame_writer (
  input  logic            clk,
  input  logic            rstn,
  input  logic            core_start,
  input  logic            core_end,
  input  logic            fifo_full,
  output logic            push,
  output logic [7:0]      push_byte,
  output io_pkg::mem_rd_t mem_rd,
  input  io_pkg::word_t   mem_data,
  input  logic            mem_data_ready
);

  io_pkg::writer_state_e state;
  logic [3:0]         byte_idx;   // position in header or pixel line
  logic [15:0]        pix_idx;
  logic               rd_pending;
  io_pkg::rgb_pixel_t pix;
  logic [7:0]         chan [3];   // red, green, blue
  logic [7:0]         rem  [3];
  io_pkg::dec3_t      dec  [3];
  io_pkg::dec3_t      cur_dec;
  logic [7:0]         pixel_byte;

  // repeated subtraction, returns {digit, remainder}
  function automatic logic [11:0] split_digit(input logic [7:0] value, input logic [7:0] unit);
    logic [3:0] digit;
    logic [7:0] rest;
    digit = 4'd0;
    rest  = value;
    for (int k = 0; k < 9; k++) begin
      if (rest >= unit) begin
        rest  = rest - unit;
        digit = digit + 4'd1;
      end
    end
    return {digit, rest};
  endfunction

  function automatic logic [7:0] const_digit(input int value, input int place);
    return 8'(io_pkg::ASCII_ZERO + (value / place) % 10);
  endfunction

  // "P3\n", width, height and color max as fixed three-digit fields
  function automatic logic [7:0] header_byte(input logic [3:0] idx);
    case (idx)
      4'd0:        return io_pkg::ASCII_P;
      4'd1:        return const_digit(3, 1);
      4'd3:        return const_digit(io_pkg::IMG_WIDTH, 100);
      4'd4:        return const_digit(io_pkg::IMG_WIDTH, 10);
      4'd5:        return const_digit(io_pkg::IMG_WIDTH, 1);
      4'd6, 4'd10: return io_pkg::ASCII_SPACE;
      4'd7:        return const_digit(io_pkg::IMG_HEIGHT, 100);
      4'd8:        return const_digit(io_pkg::IMG_HEIGHT, 10);
      4'd9:        return const_digit(io_pkg::IMG_HEIGHT, 1);
      4'd11:       return const_digit(io_pkg::COLOR_MAX, 100);
      4'd12:       return const_digit(io_pkg::COLOR_MAX, 10);
      4'd13:       return const_digit(io_pkg::COLOR_MAX, 1);
      default:     return io_pkg::ASCII_NEWLINE;
    endcase
  endfunction

  assign chan[0] = pix.red;
  assign chan[1] = pix.green;
  assign chan[2] = pix.blue;

  assign cur_dec = dec[byte_idx[3:2]];
  always_comb begin
    case (byte_idx[1:0])
      2'd0:    pixel_byte = io_pkg::ASCII_ZERO + {4'd0, cur_dec.hund};
      2'd1:    pixel_byte = io_pkg::ASCII_ZERO + {4'd0, cur_dec.tens};
      2'd2:    pixel_byte = io_pkg::ASCII_ZERO + {4'd0, cur_dec.ones};
      default: pixel_byte = (byte_idx[3:2] == 2'd2) ? io_pkg::ASCII_NEWLINE : io_pkg::ASCII_SPACE;
    endcase
  end

  assign push = !fifo_full && (state inside {io_pkg::WR_GREET, io_pkg::WR_LOADED,
                                             io_pkg::WR_HEADER, io_pkg::WR_PIXEL});
  always_comb begin
    case (state)
      io_pkg::WR_LOADED: push_byte = io_pkg::BYTE_LOADED;
      io_pkg::WR_HEADER: push_byte = header_byte(byte_idx);
      io_pkg::WR_PIXEL:  push_byte = pixel_byte;
      default:           push_byte = io_pkg::BYTE_GREETING;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= io_pkg::WR_INIT;
      byte_idx   <= '0;
      pix_idx    <= '0;
      rd_pending <= 1'b0;
      mem_rd     <= '0;
    end else begin
      mem_rd.rd <= 1'b0;
      if (mem_rd.rd) rd_pending <= 1'b1;
      else if (mem_data_ready) rd_pending <= 1'b0;
      case (state)
        io_pkg::WR_INIT:       state <= io_pkg::WR_GREET;
        io_pkg::WR_GREET:      if (push) state <= io_pkg::WR_WAIT_START;
        io_pkg::WR_WAIT_START: if (core_start) state <= io_pkg::WR_LOADED;
        io_pkg::WR_LOADED:     if (push) state <= io_pkg::WR_WAIT_END;
        io_pkg::WR_WAIT_END: begin
          byte_idx <= '0;
          if (core_end) state <= io_pkg::WR_HEADER;
        end
        io_pkg::WR_HEADER: begin
          if (push) begin
            byte_idx <= (byte_idx == 4'd14) ? 4'd0 : byte_idx + 4'd1;
            if (byte_idx == 4'd14) state <= io_pkg::WR_READ;
          end
        end
        io_pkg::WR_READ: begin
          mem_rd.addr <= io_pkg::DATA_BASE_ADDR + {14'd0, pix_idx, 2'b00};
          mem_rd.rd   <= 1'b1;
          state       <= io_pkg::WR_WAIT_DATA;
        end
        io_pkg::WR_WAIT_DATA: if (mem_data_ready) state <= io_pkg::WR_HUND;
        io_pkg::WR_HUND:      state <= io_pkg::WR_TENS;
        io_pkg::WR_TENS:      state <= io_pkg::WR_ONES;
        io_pkg::WR_ONES:      state <= io_pkg::WR_PIXEL;
        io_pkg::WR_PIXEL: begin
          if (push) begin
            byte_idx <= (byte_idx == 4'd11) ? 4'd0 : byte_idx + 4'd1;
            if (byte_idx == 4'd11) begin
              pix_idx <= pix_idx + 16'd1;
              state   <= (pix_idx == 16'(io_pkg::PIXELS - 1)) ? io_pkg::WR_IDLE
                                                             : io_pkg::WR_READ;
            end
          end
        end
        default: ; // image done, stay quiet
      endcase
    end
  end

  // pixel capture and digit split, one digit per cycle
  always_ff @(posedge clk) begin
    if (state == io_pkg::WR_WAIT_DATA && mem_data_ready) pix <= mem_data[23:0];
    for (int c = 0; c < 3; c++) begin
      if (state == io_pkg::WR_HUND) {dec[c].hund, rem[c]} <= split_digit(chan[c], 8'd100);
      if (state == io_pkg::WR_TENS) {dec[c].tens, rem[c]} <= split_digit(rem[c], 8'd10);
      if (state == io_pkg::WR_ONES) dec[c].ones <= rem[c][3:0];
    end
  end

  a_one_read: assert property (@(posedge clk) disable iff (!rstn)
    mem_rd.rd |-> !rd_pending);

endmodule

/* src/io_top.sv */
module io_top (
  input  logic              clk,
  input  logic              rstn,
  input  logic              rxd,
  output logic              txd,
  output io_pkg::instr_wr_t instr_wr,
  output logic              instr_wr_en,
  output logic              core_start,
  input  logic              core_end,
  output io_pkg::mem_rd_t   mem_rd,
  input  io_pkg::word_t     mem_data,
  input  logic              mem_data_ready
);

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       push;
  logic [7:0] push_byte;
  logic       pop;
  logic [7:0] fifo_byte;
  logic       fifo_full;
  logic       fifo_empty;

  uart_rx u_uart_rx (
    .clk      (clk),
    .rstn     (rstn),
    .rxd      (rxd),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  program_loader u_program_loader (
    .clk         (clk),
    .rstn        (rstn),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .instr_wr    (instr_wr),
    .instr_wr_en (instr_wr_en),
    .core_start  (core_start)
  );

  // producer side of the outgoing byte stream
  frame_writer u_frame_writer (
    .clk            (clk),
    .rstn           (rstn),
    .core_start     (core_start),
    .core_end       (core_end),
    .fifo_full      (fifo_full),
    .push           (push),
    .push_byte      (push_byte),
    .mem_rd         (mem_rd),
    .mem_data       (mem_data),
    .mem_data_ready (mem_data_ready)
  );

  tx_byte_fifo u_tx_byte_fifo (
    .clk        (clk),
    .rstn       (rstn),
    .push       (push),
    .push_byte  (push_byte),
    .pop        (pop),
    .fifo_byte  (fifo_byte),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

  uart_tx u_uart_tx (
    .clk        (clk),
    .rstn       (rstn),
    .fifo_empty (fifo_empty),
    .fifo_byte  (fifo_byte),
    .pop        (pop),
    .txd        (txd)
  );

endmodule

/* bench/tb_io_top.sv */
module tb_io_top;

  timeunit 1ns;
  timeprecision 100ps;

  // worst case is about 36 host bytes and 113 device bytes at ~100 cycles each,
  // plus core and memory delays, so this leaves a wide margin
  localparam int CYCLE_LIMIT = 40000;
  localparam int QUIET_CYCLES = 500;
  localparam int MAX_WORDS = 8;
  localparam int MAX_HOST_BYTES = 4 + 4 * MAX_WORDS;
  // core run outlasts the loaded byte and a fifo full of header bytes
  localparam int CORE_DELAY_MIN = (io_pkg::FIFO_DEPTH + 1) * 10 * io_pkg::CLKS_PER_BIT;

  logic              clk;
  logic              rstn;
  logic              rxd;
  logic              txd;
  io_pkg::instr_wr_t instr_wr;
  logic              instr_wr_en;
  logic              core_start;
  logic              core_end;
  io_pkg::mem_rd_t   mem_rd;
  io_pkg::word_t     mem_data;
  logic              mem_data_ready;

  logic [31:0]   rng;
  int            errors;
  int            cycle_cnt;
  int            num_words;
  int            core_delay;
  int            wr_count;
  int            rd_count;
  int            core_start_cnt;
  int            core_start_cyc;
  int            core_end_cyc;
  logic          sampling;            // txd sampler is inside a frame
  io_pkg::word_t prog_words [MAX_WORDS];
  io_pkg::word_t pixel_words [io_pkg::PIXELS];
  int            mem_delay [io_pkg::PIXELS];
  int            gaps [MAX_HOST_BYTES];
  logic [7:0]    host_q [$];
  logic [7:0]    exp_q [$];
  logic [7:0]    rx_q [$];
  int            rx_cyc [$];          // cycle where each txd start bit was seen

  io_top u_io_top (
    .clk            (clk),
    .rstn           (rstn),
    .rxd            (rxd),
    .txd            (txd),
    .instr_wr       (instr_wr),
    .instr_wr_en    (instr_wr_en),
    .core_start     (core_start),
    .core_end       (core_end),
    .mem_rd         (mem_rd),
    .mem_data       (mem_data),
    .mem_data_ready (mem_data_ready)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle_cnt++;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] draw_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // three zero-padded decimal digits
  task automatic add_dec3(input int v);
    exp_q.push_back(io_pkg::ASCII_ZERO + 8'((v / 100) % 10));
    exp_q.push_back(io_pkg::ASCII_ZERO + 8'((v / 10) % 10));
    exp_q.push_back(io_pkg::ASCII_ZERO + 8'(v % 10));
  endtask

  // serializes one frame onto rxd from 1 ns after a rising edge
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd = frame[i];
      repeat (io_pkg::CLKS_PER_BIT) @(posedge clk);
      #1;
    end
  endtask

  initial begin : txd_sampler
    logic [7:0] b;
    int         start_cyc;
    sampling = 1'b0;
    forever begin
      @(negedge clk);
      if (rstn && txd === 1'b0) begin
        sampling  = 1'b1;
        start_cyc = cycle_cnt;
        repeat (io_pkg::CLKS_PER_BIT / 2) @(negedge clk);
        if (txd !== 1'b0) report_error("txd start bit did not last half a bit");
        for (int i = 0; i < 8; i++) begin
          repeat (io_pkg::CLKS_PER_BIT) @(negedge clk);
          b[i] = txd;
        end
        repeat (io_pkg::CLKS_PER_BIT) @(negedge clk);
        if (txd !== 1'b1) report_error("txd stop bit is low");
        rx_q.push_back(b);
        rx_cyc.push_back(start_cyc);
        sampling = 1'b0;
      end
    end
  end

  // write, start and read strobes sampled away from the clock edge
  always @(negedge clk) begin
    if (rstn) begin
      if (instr_wr_en) begin
        if (wr_count >= num_words)
          report_error($sformatf("extra instruction write at addr %h", instr_wr.addr));
        else if (instr_wr.addr != 32'(wr_count * 4) || instr_wr.data != prog_words[wr_count])
          report_error($sformatf("write %0d: got addr %h data %h, expected addr %h data %h",
                                 wr_count, instr_wr.addr, instr_wr.data,
                                 32'(wr_count * 4), prog_words[wr_count]));
        wr_count++;
      end
      if (core_start) begin
        core_start_cnt++;
        core_start_cyc = cycle_cnt;
        if (!instr_wr_en || wr_count != num_words)
          report_error("core_start is not in the cycle of the last write");
      end
      if (mem_rd.rd) begin
        if (!core_end) report_error("read strobe before core_end");
        if (mem_rd.addr != io_pkg::DATA_BASE_ADDR + 32'(rd_count * 4))
          report_error($sformatf("read %0d: got addr %h", rd_count, mem_rd.addr));
        rd_count++;
      end
    end
  end

  initial begin : memory_model
    int idx;
    int served;
    served = 0;
    forever begin
      @(negedge clk);
      if (rstn && mem_rd.rd) begin
        idx = int'((mem_rd.addr - io_pkg::DATA_BASE_ADDR) >> 2);
        repeat ((served < io_pkg::PIXELS) ? mem_delay[served] : 1) @(posedge clk);
        #1;
        mem_data       = (idx >= 0 && idx < io_pkg::PIXELS) ? pixel_words[idx] : '0;
        mem_data_ready = 1'b1;
        @(posedge clk);
        #1;
        mem_data_ready = 1'b0;
        served++;
      end
    end
  end

  initial begin : core_model
    @(negedge clk);
    while (!(rstn && core_start)) @(negedge clk);
    repeat (core_delay) @(posedge clk);
    #1;
    core_end     = 1'b1;                 // held until the end of the run
    core_end_cyc = cycle_cnt;
  end

  initial begin : watchdog
    while (cycle_cnt < CYCLE_LIMIT) @(posedge clk);
    $display("timeout: the image did not arrive within %0d cycles", CYCLE_LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] len;
    clk = 1'b0;
    rstn = 1'b0;
    rxd = 1'b1;
    core_end = 1'b0;
    mem_data = '0;
    mem_data_ready = 1'b0;
    errors = 0;
    cycle_cnt = 0;
    wr_count = 0;
    rd_count = 0;
    core_start_cnt = 0;
    core_start_cyc = 0;
    core_end_cyc = 0;
    rng = 32'd89260;

    num_words = 1 + int'(draw_word() % 32'd8);
    for (int i = 0; i < MAX_WORDS; i++) prog_words[i] = draw_word();
    for (int i = 0; i < io_pkg::PIXELS; i++) begin
      pixel_words[i] = draw_word();
      mem_delay[i]   = 1 + int'(draw_word() % 32'd5);
    end
    core_delay = CORE_DELAY_MIN + int'(draw_word() % 32'd200);
    for (int i = 0; i < MAX_HOST_BYTES; i++) gaps[i] = int'(draw_word() % 32'd24);

    len = 32'(num_words * 4);
    for (int i = 0; i < 4; i++) host_q.push_back(len[8*i +: 8]);
    for (int w = 0; w < num_words; w++)
      for (int i = 0; i < 4; i++) host_q.push_back(prog_words[w][8*i +: 8]);

    // greeting, loaded, header, then one line per pixel
    exp_q.push_back(io_pkg::BYTE_GREETING);
    exp_q.push_back(io_pkg::BYTE_LOADED);
    exp_q.push_back(io_pkg::ASCII_P);
    exp_q.push_back(io_pkg::ASCII_ZERO + 8'd3);
    exp_q.push_back(io_pkg::ASCII_NEWLINE);
    add_dec3(io_pkg::IMG_WIDTH);
    exp_q.push_back(io_pkg::ASCII_SPACE);
    add_dec3(io_pkg::IMG_HEIGHT);
    exp_q.push_back(io_pkg::ASCII_SPACE);
    add_dec3(io_pkg::COLOR_MAX);
    exp_q.push_back(io_pkg::ASCII_NEWLINE);
    for (int p = 0; p < io_pkg::PIXELS; p++) begin
      add_dec3(int'(pixel_words[p][7:0]));
      exp_q.push_back(io_pkg::ASCII_SPACE);
      add_dec3(int'(pixel_words[p][15:8]));
      exp_q.push_back(io_pkg::ASCII_SPACE);
      add_dec3(int'(pixel_words[p][23:16]));
      exp_q.push_back(io_pkg::ASCII_NEWLINE);
    end

    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b1;

    for (int i = 0; i < host_q.size(); i++) begin
      send_byte(host_q[i]);
      if (gaps[i] > 0) begin
        repeat (gaps[i]) @(posedge clk);
        #1;
      end
    end

    while (rx_q.size() < exp_q.size()) @(posedge clk);
    repeat (QUIET_CYCLES) @(posedge clk);
    if (rx_q.size() != exp_q.size() || sampling)
      report_error($sformatf("txd sent %0d bytes, expected %0d and then silence",
                             rx_q.size(), exp_q.size()));
    for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
      if (rx_q[i] != exp_q[i])
        report_error($sformatf("txd byte %0d: got %h, expected %h", i, rx_q[i], exp_q[i]));
    end
    if (rx_cyc.size() > 2) begin
      if (rx_cyc[1] <= core_start_cyc) report_error("loaded byte started before core_start");
      if (rx_cyc[2] <= core_end_cyc) report_error("header started before core_end");
    end
    if (wr_count != num_words)
      report_error($sformatf("%0d instruction writes, expected %0d", wr_count, num_words));
    if (core_start_cnt != 1)
      report_error($sformatf("core_start pulsed %0d times", core_start_cnt));
    if (rd_count != io_pkg::PIXELS)
      report_error($sformatf("%0d pixel reads, expected %0d", rd_count, io_pkg::PIXELS));

    $display("writes %0d, reads %0d, txd bytes %0d, errors %0d",
             wr_count, rd_count, rx_q.size(), errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
src/io_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/program_loader.sv
src/tx_byte_fifo.sv
src/frame_writer.sv
src/io_top.sv
bench/tb_io_top.sv

/* run.sh */
#!/bin/sh
# build and run the io_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_io_top --Mdir obj_dir -o tb_io_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_io_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "no pass line found in $LOG"
  exit 1
fi
exit 0
